// File: hdl/l2_cfg_pkg.sv
`default_nettype none

package l2_cfg_pkg;

    // cache geometry
    localparam int num_ways       = 4;
    localparam int num_sets       = 4;
    localparam int words_per_line = 4;

    // address field widths
    localparam int index_w    = 2;
    localparam int word_off_w = 2;
    localparam int tag_w      = 32 - index_w - word_off_w - 2;

    localparam int way_w = 2;

    // one bit per tree node, three nodes for four ways
    localparam int plru_w = 3;

endpackage

`default_nettype wire

// File: hdl/l2_bus_pkg.sv
`default_nettype none

package l2_bus_pkg;

    import l2_cfg_pkg::*;

    // cache address, seen as a word or as its fields
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [tag_w-1:0]      tag;
            logic [index_w-1:0]    index;
            logic [word_off_w-1:0] offset;
            logic [1:0]            byte_off;
        } f;
    } l2_addr_t;

    // who owns the request buffer
    typedef enum logic [1:0] {
        src_none   = 2'd0,
        src_iread  = 2'd1,
        src_dread  = 2'd2,
        src_dwrite = 2'd3
    } l2_src_e;

    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire

// File: hdl/l2_req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module l2_req_arbiter
    import l2_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_req,
    input  logic [31:0] i_addr,
    input  logic        d_req,
    input  logic        d_we,
    input  logic [31:0] d_addr,
    input  logic [31:0] d_wdata,
    input  logic [3:0]  d_wstrb,
    input  logic        grant,
    output logic        buf_valid,
    output l2_src_e     buf_src,
    output l2_addr_t    buf_addr,
    output logic [31:0] buf_wdata,
    output logic [3:0]  buf_wstrb
);

    l2_src_e win_src;
    logic    capture;
    logic    src_req;

    // data port first
    always_comb begin
        if (d_req)
            win_src = d_we ? src_dwrite : src_dread;
        else if (i_req)
            win_src = src_iread;
        else
            win_src = src_none;
    end

    assign capture = grant && !buf_valid && (win_src != src_none);

    // req of the client that owns the buffer
    assign src_req = (buf_src == src_iread) ? i_req : d_req;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_valid <= 1'b0;
            buf_src   <= src_none;
        end else if (capture) begin
            buf_valid <= 1'b1;
            buf_src   <= win_src;
        end else if (buf_valid && !src_req) begin
            // client released, buffer free again
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_addr.word <= d_req ? d_addr : i_addr;
            buf_wdata     <= d_wdata;
            buf_wstrb     <= d_wstrb;
        end
    end

endmodule

`default_nettype wire

// File: hdl/l2_tag_dirty.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tag_dirty
    import l2_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic [index_w-1:0]  rd_index,
    input  logic [tag_w-1:0]    cmp_tag,
    input  logic                wr_en,
    input  logic [way_w-1:0]    wr_way,
    input  logic [tag_w-1:0]    wr_tag,
    input  logic                set_dirty,
    input  logic                clr_dirty,
    input  logic [way_w-1:0]    victim_way,
    output logic [num_ways-1:0] hit_vec,
    output logic [num_ways-1:0] valid_vec,
    output logic                victim_dirty,
    output logic [tag_w-1:0]    victim_tag
);

    logic [tag_w-1:0]    tag_mem [num_sets][num_ways];
    logic [num_ways-1:0] valid_q [num_sets];
    logic [num_ways-1:0] dirty_q [num_sets];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (wr_en)
                valid_q[rd_index][wr_way] <= 1'b1;
            if (set_dirty)
                dirty_q[rd_index][wr_way] <= 1'b1;
            else if (clr_dirty)
                dirty_q[rd_index][wr_way] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            tag_mem[rd_index][wr_way] <= wr_tag;
    end

    // all ways of the set compared at once
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] <= valid_q[rd_index][w] && (tag_mem[rd_index][w] == cmp_tag);
        end
        valid_vec    <= valid_q[rd_index];
        victim_dirty <= dirty_q[rd_index][victim_way];
        victim_tag   <= tag_mem[rd_index][victim_way];
    end

endmodule

`default_nettype wire

// File: hdl/l2_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module l2_data_ram
    import l2_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic [index_w-1:0]    index,
    input  logic [way_w-1:0]      way,
    input  logic [word_off_w-1:0] word,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wr_en,
    output logic [31:0]           rdata
);

    logic [31:0] mem [num_sets * num_ways * words_per_line];
    logic [index_w+way_w+word_off_w-1:0] addr;

    // set, then way, then word
    assign addr = {index, way, word};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b])
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        // old word on a same-cycle write
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: hdl/l2_plru.sv
`timescale 1ns/1ps
`default_nettype none

module l2_plru
    import l2_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic [index_w-1:0]  index,
    input  logic                touch,
    input  logic [way_w-1:0]    touch_way,
    input  logic [num_ways-1:0] valid_vec,
    output logic [way_w-1:0]    victim_way
);

    // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3
    logic [plru_w-1:0] tree_q [num_sets];
    logic [plru_w-1:0] tree;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++)
                tree_q[s] <= '0;
        end else if (touch) begin
            tree_q[index][0] <= ~touch_way[1];
            if (touch_way[1])
                tree_q[index][2] <= ~touch_way[0];
            else
                tree_q[index][1] <= ~touch_way[0];
        end
    end

    always_comb begin
        tree       = tree_q[index];
        victim_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
        // an empty way beats the tree, lowest one wins
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_vec[w])
                victim_way = way_w'(w);
        end
    end

endmodule

`default_nettype wire

// File: hdl/l2_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module l2_beat_counter
    import l2_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  clear,
    input  logic                  step,
    output logic [word_off_w-1:0] beat,
    output logic                  last_beat
);

    // wraps to zero after the last word
    always_ff @(posedge clk) begin
        if (!rstn)
            beat <= '0;
        else if (clear)
            beat <= '0;
        else if (step)
            beat <= beat + 1'b1;
    end

    assign last_beat = (beat == word_off_w'(words_per_line - 1));

endmodule

`default_nettype wire

// File: hdl/l2_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_fsm
    import l2_cfg_pkg::*;
    import l2_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  buf_valid,
    input  l2_src_e               buf_src,
    input  l2_addr_t              buf_addr,
    input  logic [num_ways-1:0]   hit_vec,
    input  logic                  victim_dirty,
    input  logic [tag_w-1:0]      victim_tag,
    input  logic [way_w-1:0]      victim_way,
    input  logic                  last_beat,
    input  logic [word_off_w-1:0] beat,
    input  logic                  mem_ack,
    output logic                  grant,
    output logic                  i_ack,
    output logic                  d_ack,
    output logic                  mem_req,
    output mem_op_e               mem_op,
    output logic [31:0]           mem_addr,
    output logic                  tag_wr_en,
    output logic                  set_dirty,
    output logic                  clr_dirty,
    output logic                  data_wr_en,
    output logic                  data_sel_refill,
    output logic                  touch,
    output logic                  cnt_clear,
    output logic                  cnt_step,
    output logic [way_w-1:0]      sel_way,
    output logic [word_off_w-1:0] ram_word
);

    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_lookup    = 3'd1;
    localparam logic [2:0] st_writeback = 3'd2;
    localparam logic [2:0] st_refill    = 3'd3;
    localparam logic [2:0] st_respond   = 3'd4;
    localparam logic [2:0] st_release   = 3'd5;

    // per-beat handshake phases
    localparam logic [1:0] ph_setup = 2'd0;
    localparam logic [1:0] ph_req   = 2'd1;
    localparam logic [1:0] ph_drop  = 2'd2;

    logic [2:0]       state;
    logic [1:0]       phase;
    logic [way_w-1:0] hit_way;
    logic             in_xfer;
    logic             beat_done;
    l2_addr_t         wb_addr;
    l2_addr_t         rf_addr;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w])
                hit_way = way_w'(w);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= st_idle;
            phase   <= ph_setup;
            sel_way <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (buf_valid)
                        state <= st_lookup;
                end
                st_lookup: begin
                    phase <= ph_setup;
                    if (|hit_vec) begin
                        sel_way <= hit_way;
                        state   <= st_respond;
                    end else begin
                        sel_way <= victim_way;
                        state   <= st_writeback;
                    end
                end
                st_writeback, st_refill: begin
                    case (phase)
                        ph_setup: begin
                            // clean victim goes straight to refill
                            if (state == st_writeback && !victim_dirty)
                                state <= st_refill;
                            else
                                phase <= ph_req;
                        end
                        ph_req: begin
                            if (mem_ack)
                                phase <= ph_drop;
                        end
                        default: begin
                            if (!mem_ack) begin
                                phase <= ph_setup;
                                if (last_beat)
                                    state <= (state == st_writeback) ? st_refill : st_respond;
                            end
                        end
                    endcase
                end
                st_respond: state <= st_release;
                // wait for the client to drop req
                st_release: begin
                    if (!buf_valid)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign in_xfer   = (state == st_writeback) || (state == st_refill);
    assign beat_done = in_xfer && (phase == ph_drop) && !mem_ack;

    // line-aligned address plus beat
    always_comb begin
        wb_addr.f.tag      = victim_tag;
        wb_addr.f.index    = buf_addr.f.index;
        wb_addr.f.offset   = beat;
        wb_addr.f.byte_off = 2'b00;
        rf_addr            = wb_addr;
        rf_addr.f.tag      = buf_addr.f.tag;
    end

    assign grant    = (state == st_idle);
    assign i_ack    = (state == st_release) && (buf_src == src_iread);
    assign d_ack    = (state == st_release) && (buf_src == src_dread || buf_src == src_dwrite);
    assign mem_req  = in_xfer && (phase == ph_req);
    assign mem_op   = (state == st_writeback) ? mem_write : mem_read;
    assign mem_addr = (state == st_writeback) ? wb_addr.word : rf_addr.word;

    assign cnt_clear = (state == st_lookup);
    assign cnt_step  = beat_done;

    assign tag_wr_en       = (state == st_refill) && beat_done && last_beat;
    assign clr_dirty       = (state == st_writeback) && beat_done && last_beat;
    assign set_dirty       = (state == st_respond) && (buf_src == src_dwrite);
    assign data_sel_refill = (state == st_refill);
    assign data_wr_en      = set_dirty || (data_sel_refill && phase == ph_req && mem_ack);
    assign touch           = (state == st_respond);
    assign ram_word        = in_xfer ? beat : buf_addr.f.offset;

endmodule

`default_nettype wire

// File: hdl/l2_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top
    import l2_cfg_pkg::*;
    import l2_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_req,
    input  logic [31:0] i_addr,
    output logic        i_ack,
    output logic [31:0] i_rdata,
    input  logic        d_req,
    input  logic        d_we,
    input  logic [31:0] d_addr,
    input  logic [31:0] d_wdata,
    input  logic [3:0]  d_wstrb,
    output logic        d_ack,
    output logic [31:0] d_rdata,
    output logic        mem_req,
    output mem_op_e     mem_op,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    input  logic [31:0] mem_rdata,
    input  logic        mem_ack
);

    logic                  grant;
    logic                  buf_valid;
    l2_src_e               buf_src;
    l2_addr_t              buf_addr;
    logic [31:0]           buf_wdata;
    logic [3:0]            buf_wstrb;
    logic [num_ways-1:0]   hit_vec;
    logic [num_ways-1:0]   valid_vec;
    logic                  victim_dirty;
    logic [tag_w-1:0]      victim_tag;
    logic [way_w-1:0]      victim_way;
    logic [way_w-1:0]      sel_way;
    logic [word_off_w-1:0] beat;
    logic [word_off_w-1:0] ram_word;
    logic                  last_beat;
    logic                  tag_wr_en;
    logic                  set_dirty;
    logic                  clr_dirty;
    logic                  data_wr_en;
    logic                  data_sel_refill;
    logic                  touch;
    logic                  cnt_clear;
    logic                  cnt_step;
    logic [31:0]           ram_rdata;
    logic [31:0]           ram_wdata;
    logic [3:0]            ram_wstrb;

    // refill writes whole words from memory
    assign ram_wdata = data_sel_refill ? mem_rdata : buf_wdata;
    assign ram_wstrb = data_sel_refill ? 4'hf : buf_wstrb;

    assign i_rdata   = ram_rdata;
    assign d_rdata   = ram_rdata;
    assign mem_wdata = ram_rdata;

    l2_req_arbiter u_arb (
        .clk(clk), .rstn(rstn),
        .i_req(i_req), .i_addr(i_addr),
        .d_req(d_req), .d_we(d_we), .d_addr(d_addr),
        .d_wdata(d_wdata), .d_wstrb(d_wstrb),
        .grant(grant),
        .buf_valid(buf_valid), .buf_src(buf_src), .buf_addr(buf_addr),
        .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb)
    );

    l2_tag_dirty u_tags (
        .clk(clk), .rstn(rstn),
        .rd_index(buf_addr.f.index), .cmp_tag(buf_addr.f.tag),
        .wr_en(tag_wr_en), .wr_way(sel_way), .wr_tag(buf_addr.f.tag),
        .set_dirty(set_dirty), .clr_dirty(clr_dirty),
        .victim_way(victim_way),
        .hit_vec(hit_vec), .valid_vec(valid_vec),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    l2_data_ram u_data (
        .clk(clk),
        .index(buf_addr.f.index), .way(sel_way), .word(ram_word),
        .wdata(ram_wdata), .wstrb(ram_wstrb), .wr_en(data_wr_en),
        .rdata(ram_rdata)
    );

    l2_plru u_plru (
        .clk(clk), .rstn(rstn),
        .index(buf_addr.f.index),
        .touch(touch), .touch_way(sel_way),
        .valid_vec(valid_vec),
        .victim_way(victim_way)
    );

    l2_beat_counter u_beats (
        .clk(clk), .rstn(rstn),
        .clear(cnt_clear), .step(cnt_step),
        .beat(beat), .last_beat(last_beat)
    );

    l2_ctrl_fsm u_ctrl (
        .clk(clk), .rstn(rstn),
        .buf_valid(buf_valid), .buf_src(buf_src), .buf_addr(buf_addr),
        .hit_vec(hit_vec), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_way(victim_way),
        .last_beat(last_beat), .beat(beat), .mem_ack(mem_ack),
        .grant(grant), .i_ack(i_ack), .d_ack(d_ack),
        .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr),
        .tag_wr_en(tag_wr_en), .set_dirty(set_dirty), .clr_dirty(clr_dirty),
        .data_wr_en(data_wr_en), .data_sel_refill(data_sel_refill),
        .touch(touch), .cnt_clear(cnt_clear), .cnt_step(cnt_step),
        .sel_way(sel_way), .ram_word(ram_word)
    );

endmodule

`default_nettype wire

// File: dv/l2_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb
    import l2_cfg_pkg::*;
    import l2_bus_pkg::*;
();

    localparam int fields            = 8;
    localparam int max_tests         = 32;
    localparam int cycles_per_access = 200;
    localparam int reset_cycles      = 5;

    logic        clk;
    logic        rstn;
    logic        i_req;
    logic [31:0] i_addr;
    logic        i_ack;
    logic [31:0] i_rdata;
    logic        d_req;
    logic        d_we;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic [3:0]  d_wstrb;
    logic        d_ack;
    logic [31:0] d_rdata;
    logic        mem_req;
    mem_op_e     mem_op;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_ack;

    logic [31:0] stim [fields * max_tests];
    // bytes 0x000 to 0x3ff of the backing memory
    logic [31:0] mem_model [256];
    int unsigned lcg_state;
    int          rd_beats;
    int          wr_beats;
    int          errors;
    int          num_tests;
    int          tests_run;
    int          tests_ok;
    int          watchdog_cycles;

    l2_cache_top uut (
        .clk(clk), .rstn(rstn),
        .i_req(i_req), .i_addr(i_addr), .i_ack(i_ack), .i_rdata(i_rdata),
        .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_wstrb(d_wstrb), .d_ack(d_ack), .d_rdata(d_rdata),
        .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
    );

    always #2 clk = ~clk;

    // memory ack delay of 0 to 3 cycles
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 4);
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail %0d ns: %s returned %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_traffic(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail %0d ns: %s counted %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic drive_request(input int port, input int base);
        if (port == 0) begin
            i_req  <= 1'b1;
            i_addr <= stim[base + 2];
        end else begin
            d_req   <= 1'b1;
            d_we    <= stim[base + 1][0];
            d_addr  <= stim[base + 2];
            d_wdata <= stim[base + 3];
            d_wstrb <= stim[base + 4][3:0];
        end
    endtask

    task automatic finish_request(input int port, input int base);
        int          errors_before;
        logic        ack_seen;
        logic        we;
        logic [31:0] got;
        string       what;
        errors_before = errors;
        we   = (port != 0) && stim[base + 1][0];
        what = $sformatf("%s %s %h", (port == 0) ? "instr" : "data",
                         we ? "write" : "read", stim[base + 2]);
        ack_seen = 1'b0;
        while (!ack_seen) begin
            @(posedge clk);
            ack_seen = (port == 0) ? i_ack : d_ack;
            if ((port == 0) ? d_ack : i_ack) begin
                $display("%0d ns: %s, the other port was acknowledged first", $time, what);
                errors++;
            end
        end
        got = (port == 0) ? i_rdata : d_rdata;
        if (!we)
            check_word(got, stim[base + 5], what);
        check_traffic(rd_beats, stim[base + 6][0] ? words_per_line : 0, {what, " mem reads"});
        check_traffic(wr_beats, stim[base + 7][0] ? words_per_line : 0, {what, " mem writes"});
        rd_beats = 0;
        wr_beats = 0;
        if (port == 0)
            i_req <= 1'b0;
        else
            d_req <= 1'b0;
        while ((port == 0) ? i_ack : d_ack)
            @(posedge clk);
        tests_run++;
        if (errors == errors_before) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, what);
        end else begin
            $display("test %0d %s: error", tests_run, what);
        end
    endtask

    // answers one beat at a time and holds ack until req drops
    initial begin : memory_model
        int          delay;
        logic [31:0] a;
        forever begin
            @(posedge clk);
            if (mem_req) begin
                delay = next_delay();
                repeat (delay) @(posedge clk);
                a = mem_addr;
                if (a[31:10] != '0 || a[1:0] != 2'b00) begin
                    $display("memory model: address %h is outside the modeled range", a);
                    errors++;
                end else if (mem_op == mem_write) begin
                    mem_model[a[9:2]] = mem_wdata;
                    wr_beats++;
                end else begin
                    mem_rdata <= mem_model[a[9:2]];
                    rd_beats++;
                end
                mem_ack <= 1'b1;
                while (mem_req)
                    @(posedge clk);
                delay = next_delay();
                repeat (delay) @(posedge clk);
                mem_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int n;
        int base;
        int errors_before;
        clk       = 1'b0;
        rstn      = 1'b0;
        i_req     = 1'b0;
        i_addr    = '0;
        d_req     = 1'b0;
        d_we      = 1'b0;
        d_addr    = '0;
        d_wdata   = '0;
        d_wstrb   = '0;
        mem_rdata = '0;
        mem_ack   = 1'b0;
        lcg_state = 72;
        rd_beats  = 0;
        wr_beats  = 0;
        errors    = 0;
        tests_run = 0;
        tests_ok  = 0;
        watchdog_cycles = 0;
        // each word holds its own inverted byte address
        for (int i = 0; i < 256; i++)
            mem_model[i] = ~(32'(i) << 2);
        for (int i = 0; i < fields * max_tests; i++)
            stim[i] = 32'hffff_ffff;
        $readmemh("dv/l2_stimulus.txt", stim);
        num_tests = 0;
        while (num_tests < max_tests && stim[num_tests * fields] !== 32'hffff_ffff)
            num_tests++;
        watchdog_cycles = (num_tests + 1) * cycles_per_access + reset_cycles;

        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;

        // nothing may move before the first request
        errors_before = errors;
        repeat (4) begin
            @(posedge clk);
            if (i_ack || d_ack || mem_req) begin
                $display("%0d ns: ack or mem_req high with no request pending", $time);
                errors++;
            end
        end
        tests_run++;
        if (errors == errors_before) begin
            tests_ok++;
            $display("test %0d idle after reset: ok", tests_run);
        end else begin
            $display("test %0d idle after reset: error", tests_run);
        end

        if (num_tests == 0) begin
            $display("the stimulus file holds no accesses");
            errors++;
        end

        n = 0;
        while (n < num_tests) begin
            base = n * fields;
            @(posedge clk);
            rd_beats = 0;
            wr_beats = 0;
            if (stim[base] == 32'd2 && n + 1 < num_tests) begin
                drive_request(1, base);
                drive_request(0, base + fields);
                finish_request(1, base);
                finish_request(0, base + fields);
                n += 2;
            end else begin
                drive_request((stim[base] == 32'd0) ? 0 : 1, base);
                finish_request((stim[base] == 32'd0) ? 0 : 1, base);
                n++;
            end
        end

        $display("tests run %0d, ok %0d, errors %0d", tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/l2_cfg_pkg.sv
hdl/l2_bus_pkg.sv
hdl/l2_req_arbiter.sv
hdl/l2_tag_dirty.sv
hdl/l2_data_ram.sv
hdl/l2_plru.sv
hdl/l2_beat_counter.sv
hdl/l2_ctrl_fsm.sv
hdl/l2_cache_top.sv
dv/l2_cache_tb.sv

// File: dv/l2_stimulus.txt
// port we addr wdata strb exp_rdata miss wb   (port 0 = instr, 1 = data)
// port 2 = data read raised together with the instruction read on the next line
0 0 00000004 00000000 0 fffffffb 1 0
1 0 00000008 00000000 0 fffffff7 0 0
0 0 00000004 00000000 0 fffffffb 0 0
1 1 0000000c 12345678 3 00000000 0 0
1 0 0000000c 00000000 0 ffff5678 0 0
1 0 00000040 00000000 0 ffffffbf 1 0
1 0 00000084 00000000 0 ffffff7b 1 0
0 0 000000c8 00000000 0 ffffff37 1 0
1 0 00000100 00000000 0 fffffeff 1 1
0 0 0000000c 00000000 0 ffff5678 1 0
1 1 00000154 a5a5a5a5 c 00000000 1 0
1 0 00000154 00000000 0 a5a5feab 0 0
2 0 00000268 00000000 0 fffffd97 1 0
0 0 000000c4 00000000 0 ffffff3b 0 0
